/* Makefile */
# Verilator build, run and lint of the register block regression

SIM        := verilator
TOP        := tb_fpga_reg_top
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* rtl/ctrl_regs.sv */
// Control registers
// Device ID, mode select, PWM enable and PWM idle polarity,
// written from the bus slave select strobes

`timescale 1ns/1ps

module ctrl_regs (
  input  logic                                wbs_clk_i,
  input  logic                                wbs_rst_i,
  input  logic                                id_wr_i,
  input  logic                                mode_wr_i,
  input  logic                                en_pol_wr_i,
  input  logic [fpga_bus_pkg::BYTE_LANES-1:0] byte_stb_i,
  input  logic [fpga_bus_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [fpga_bus_pkg::DATA_WIDTH-1:0] device_id_o,
  output logic [fpga_reg_pkg::MODE_WIDTH-1:0] mode_sel_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH-1:0] pwm_en_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH-1:0] idle_pol_o
);

  always_ff @(posedge wbs_clk_i or posedge wbs_rst_i) begin
    if (wbs_rst_i) begin
      device_id_o <= fpga_reg_pkg::DEVICE_ID_RESET;
      mode_sel_o  <= '0;
      pwm_en_o    <= '0;
      idle_pol_o  <= '0;
    end else begin
      // Every byte lane of the device ID is writable
      for (int i = 0; i < fpga_bus_pkg::BYTE_LANES; i++) begin
        if (id_wr_i && byte_stb_i[i]) begin
          device_id_o[8*i +: 8] <= wdata_i[8*i +: 8];
        end
      end

      if (mode_wr_i && byte_stb_i[0]) begin
        mode_sel_o <= wdata_i[fpga_reg_pkg::MODE_WIDTH-1:0];
      end

      // Enables in lane 0, idle polarity in lane 1
      if (en_pol_wr_i && byte_stb_i[0]) begin
        pwm_en_o <= wdata_i[fpga_reg_pkg::NUM_PWM_CH-1:0];
      end
      if (en_pol_wr_i && byte_stb_i[1]) begin
        idle_pol_o <= wdata_i[8 +: fpga_reg_pkg::NUM_PWM_CH];
      end
    end
  end

endmodule

/* rtl/fpga_bus_pkg.sv */
// Host bus package
// Widths and byte-lane count for the Wishbone-style register bus
// between the host processor and the fabric register block

package fpga_bus_pkg;

  // Word address, enough for 128 registers
  localparam int ADDR_WIDTH = 7;

  // Data bus width
  localparam int DATA_WIDTH = 32;

  // One strobe per data byte
  localparam int BYTE_LANES = DATA_WIDTH / 8;

endpackage

/* rtl/fpga_reg_pkg.sv */
// Register map package
// Addresses, field widths and reset values of the GPIO and PWM
// configuration registers seen by the host

package fpga_reg_pkg;

  // ----------------------------------------------------------------------
  // Register addresses
  // ----------------------------------------------------------------------
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_DEVICE_ID   = 7'h00;
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_MODE_SEL    = 7'h01;
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_GPIO_IN_LO  = 7'h02;
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_GPIO_IN_HI  = 7'h03;
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_GPIO_OUT_LO = 7'h04;
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_GPIO_OUT_HI = 7'h05;
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_GPIO_OE_LO  = 7'h06;
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_GPIO_OE_HI  = 7'h07;
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_PWM_EN_POL  = 7'h08;

  // Channel n has its duty register at base + 2n and its period just above
  localparam logic [fpga_bus_pkg::ADDR_WIDTH-1:0] ADR_PWM_BASE    = 7'h09;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------
  localparam int GPIO_WIDTH    = 46;
  localparam int GPIO_LO_WIDTH = 32;
  localparam int NUM_PWM_CH    = 4;
  localparam int PWM_REG_WIDTH = 16;
  localparam int MODE_WIDTH    = 4;

  // ----------------------------------------------------------------------
  // Fixed values
  // ----------------------------------------------------------------------
  localparam logic [fpga_bus_pkg::DATA_WIDTH-1:0] DEVICE_ID_RESET    = 32'hCE1A_0001;

  // Returned for any unmapped address
  localparam logic [fpga_bus_pkg::DATA_WIDTH-1:0] DEFAULT_READ_VALUE = 32'hFABD_EFAC;

endpackage

/* rtl/fpga_reg_top.sv */
// FPGA register block top level
// Host bus slave with control, GPIO and four PWM channel register
// blocks behind it

`timescale 1ns/1ps

module fpga_reg_top (
  input  logic                                   wbs_clk_i,
  input  logic                                   wbs_rst_i,
  input  logic [fpga_bus_pkg::ADDR_WIDTH-1:0]    wbs_adr_i,
  input  logic                                   wbs_cyc_i,
  input  logic                                   wbs_stb_i,
  input  logic                                   wbs_we_i,
  input  logic [fpga_bus_pkg::BYTE_LANES-1:0]    wbs_byte_stb_i,
  input  logic [fpga_bus_pkg::DATA_WIDTH-1:0]    wbs_dat_i,
  input  logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    gpio_in_i,
  output logic [fpga_bus_pkg::DATA_WIDTH-1:0]    wbs_dat_o,
  output logic                                   wbs_ack_o,
  output logic [fpga_bus_pkg::DATA_WIDTH-1:0]    device_id_o,
  output logic [fpga_reg_pkg::MODE_WIDTH-1:0]    mode_sel_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    pwm_en_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    idle_pol_o,
  output logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    gpio_out_o,
  output logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    gpio_oe_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH*fpga_reg_pkg::PWM_REG_WIDTH-1:0] duty_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH*fpga_reg_pkg::PWM_REG_WIDTH-1:0] period_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    duty_upd_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    period_upd_o
);

  // Write selects and shared write data from the bus slave
  logic                                id_wr;
  logic                                mode_wr;
  logic                                en_pol_wr;
  logic [1:0]                          gpio_out_wr;
  logic [1:0]                          gpio_oe_wr;
  logic [fpga_reg_pkg::NUM_PWM_CH-1:0] duty_wr;
  logic [fpga_reg_pkg::NUM_PWM_CH-1:0] period_wr;
  logic [fpga_bus_pkg::BYTE_LANES-1:0] byte_stb;
  logic [fpga_bus_pkg::DATA_WIDTH-1:0] wdata;

  wb_reg_slave u_slave (
    .wbs_clk_i      (wbs_clk_i),
    .wbs_rst_i      (wbs_rst_i),
    .wbs_adr_i      (wbs_adr_i),
    .wbs_cyc_i      (wbs_cyc_i),
    .wbs_stb_i      (wbs_stb_i),
    .wbs_we_i       (wbs_we_i),
    .wbs_byte_stb_i (wbs_byte_stb_i),
    .wbs_dat_i      (wbs_dat_i),
    .device_id_i    (device_id_o),
    .mode_sel_i     (mode_sel_o),
    .pwm_en_i       (pwm_en_o),
    .idle_pol_i     (idle_pol_o),
    .gpio_in_i      (gpio_in_i),
    .gpio_out_i     (gpio_out_o),
    .gpio_oe_i      (gpio_oe_o),
    .duty_i         (duty_o),
    .period_i       (period_o),
    .wbs_dat_o      (wbs_dat_o),
    .wbs_ack_o      (wbs_ack_o),
    .id_wr_o        (id_wr),
    .mode_wr_o      (mode_wr),
    .en_pol_wr_o    (en_pol_wr),
    .gpio_out_wr_o  (gpio_out_wr),
    .gpio_oe_wr_o   (gpio_oe_wr),
    .duty_wr_o      (duty_wr),
    .period_wr_o    (period_wr),
    .byte_stb_o     (byte_stb),
    .wdata_o        (wdata)
  );

  ctrl_regs u_ctrl (
    .wbs_clk_i   (wbs_clk_i),
    .wbs_rst_i   (wbs_rst_i),
    .id_wr_i     (id_wr),
    .mode_wr_i   (mode_wr),
    .en_pol_wr_i (en_pol_wr),
    .byte_stb_i  (byte_stb),
    .wdata_i     (wdata),
    .device_id_o (device_id_o),
    .mode_sel_o  (mode_sel_o),
    .pwm_en_o    (pwm_en_o),
    .idle_pol_o  (idle_pol_o)
  );

  gpio_regs u_gpio (
    .wbs_clk_i     (wbs_clk_i),
    .wbs_rst_i     (wbs_rst_i),
    .gpio_out_wr_i (gpio_out_wr),
    .gpio_oe_wr_i  (gpio_oe_wr),
    .byte_stb_i    (byte_stb),
    .wdata_i       (wdata),
    .gpio_out_o    (gpio_out_o),
    .gpio_oe_o     (gpio_oe_o)
  );

  // ----------------------------------------------------------------------
  // PWM channels
  // ----------------------------------------------------------------------
  for (genvar ch = 0; ch < fpga_reg_pkg::NUM_PWM_CH; ch++) begin : g_pwm_ch
    pwm_ch_regs u_pwm_ch (
      .wbs_clk_i    (wbs_clk_i),
      .wbs_rst_i    (wbs_rst_i),
      .duty_wr_i    (duty_wr[ch]),
      .period_wr_i  (period_wr[ch]),
      .byte_stb_i   (byte_stb),
      .wdata_i      (wdata),
      .duty_o       (duty_o[ch*fpga_reg_pkg::PWM_REG_WIDTH +: fpga_reg_pkg::PWM_REG_WIDTH]),
      .period_o     (period_o[ch*fpga_reg_pkg::PWM_REG_WIDTH +: fpga_reg_pkg::PWM_REG_WIDTH]),
      .duty_upd_o   (duty_upd_o[ch]),
      .period_upd_o (period_upd_o[ch])
    );
  end

endmodule

/* rtl/gpio_regs.sv */
// GPIO registers
// 46-bit output and output-enable registers, each split over a low
// word and a high word with byte-lane writes

`timescale 1ns/1ps

module gpio_regs (
  input  logic                                wbs_clk_i,
  input  logic                                wbs_rst_i,
  input  logic [1:0]                          gpio_out_wr_i,
  input  logic [1:0]                          gpio_oe_wr_i,
  input  logic [fpga_bus_pkg::BYTE_LANES-1:0] byte_stb_i,
  input  logic [fpga_bus_pkg::DATA_WIDTH-1:0] wdata_i,
  output logic [fpga_reg_pkg::GPIO_WIDTH-1:0] gpio_out_o,
  output logic [fpga_reg_pkg::GPIO_WIDTH-1:0] gpio_oe_o
);

  // Next value of one 46-bit register with wr[0] for the low word and wr[1] for the high
  function automatic logic [fpga_reg_pkg::GPIO_WIDTH-1:0] lane_merge(
    input logic [fpga_reg_pkg::GPIO_WIDTH-1:0] cur,
    input logic [1:0]                          wr,
    input logic [fpga_bus_pkg::BYTE_LANES-1:0] stb,
    input logic [fpga_bus_pkg::DATA_WIDTH-1:0] wd
  );
    logic [fpga_reg_pkg::GPIO_WIDTH-1:0] nxt;
    nxt = cur;
    for (int i = 0; i < fpga_bus_pkg::BYTE_LANES; i++) begin
      if (wr[0] && stb[i]) begin
        nxt[8*i +: 8] = wd[8*i +: 8];
      end
    end
    // High word has only lanes 0 and 1 with six bits in lane 1
    if (wr[1] && stb[0]) begin
      nxt[fpga_reg_pkg::GPIO_LO_WIDTH +: 8] = wd[7:0];
    end
    if (wr[1] && stb[1]) begin
      nxt[fpga_reg_pkg::GPIO_WIDTH-1:fpga_reg_pkg::GPIO_LO_WIDTH+8] =
        wd[fpga_reg_pkg::GPIO_WIDTH-fpga_reg_pkg::GPIO_LO_WIDTH-1:8];
    end
    return nxt;
  endfunction

  always_ff @(posedge wbs_clk_i or posedge wbs_rst_i) begin
    if (wbs_rst_i) begin
      gpio_out_o <= '0;
      gpio_oe_o  <= '0;
    end else begin
      gpio_out_o <= lane_merge(gpio_out_o, gpio_out_wr_i, byte_stb_i, wdata_i);
      gpio_oe_o  <= lane_merge(gpio_oe_o, gpio_oe_wr_i, byte_stb_i, wdata_i);
    end
  end

endmodule

/* rtl/pwm_ch_regs.sv */
// PWM channel registers
// Duty and period of one channel, each with an update pulse that
// tells the PWM engine to reload after a host write

`timescale 1ns/1ps

module pwm_ch_regs (
  input  logic                                   wbs_clk_i,
  input  logic                                   wbs_rst_i,
  input  logic                                   duty_wr_i,
  input  logic                                   period_wr_i,
  input  logic [fpga_bus_pkg::BYTE_LANES-1:0]    byte_stb_i,
  input  logic [fpga_bus_pkg::DATA_WIDTH-1:0]    wdata_i,
  output logic [fpga_reg_pkg::PWM_REG_WIDTH-1:0] duty_o,
  output logic [fpga_reg_pkg::PWM_REG_WIDTH-1:0] period_o,
  output logic                                   duty_upd_o,
  output logic                                   period_upd_o
);

  logic duty_wr_q;
  logic period_wr_q;

  // Byte-lane write into a 16-bit register, lanes 0 and 1
  function automatic logic [fpga_reg_pkg::PWM_REG_WIDTH-1:0] lane_merge(
    input logic [fpga_reg_pkg::PWM_REG_WIDTH-1:0] cur,
    input logic                                   wr,
    input logic [fpga_bus_pkg::BYTE_LANES-1:0]    stb,
    input logic [fpga_bus_pkg::DATA_WIDTH-1:0]    wd
  );
    logic [fpga_reg_pkg::PWM_REG_WIDTH-1:0] nxt;
    nxt = cur;
    for (int i = 0; i < fpga_reg_pkg::PWM_REG_WIDTH / 8; i++) begin
      if (wr && stb[i]) begin
        nxt[8*i +: 8] = wd[8*i +: 8];
      end
    end
    return nxt;
  endfunction

  always_ff @(posedge wbs_clk_i or posedge wbs_rst_i) begin
    if (wbs_rst_i) begin
      duty_o       <= '0;
      period_o     <= '0;
      duty_wr_q    <= 1'b0;
      period_wr_q  <= 1'b0;
      duty_upd_o   <= 1'b0;
      period_upd_o <= 1'b0;
    end else begin
      duty_o       <= lane_merge(duty_o, duty_wr_i, byte_stb_i, wdata_i);
      period_o     <= lane_merge(period_o, period_wr_i, byte_stb_i, wdata_i);
      // Pulse lands one cycle after ack even when no lane is strobed
      duty_wr_q    <= duty_wr_i;
      period_wr_q  <= period_wr_i;
      duty_upd_o   <= duty_wr_q;
      period_upd_o <= period_wr_q;
    end
  end

endmodule

/* rtl/wb_reg_slave.sv */
// Register bus slave
// Generates the one-cycle acknowledge, decodes writes into one-cycle
// register select strobes and builds the read word from field values

`timescale 1ns/1ps

module wb_reg_slave (
  input  logic                                   wbs_clk_i,
  input  logic                                   wbs_rst_i,
  input  logic [fpga_bus_pkg::ADDR_WIDTH-1:0]    wbs_adr_i,
  input  logic                                   wbs_cyc_i,
  input  logic                                   wbs_stb_i,
  input  logic                                   wbs_we_i,
  input  logic [fpga_bus_pkg::BYTE_LANES-1:0]    wbs_byte_stb_i,
  input  logic [fpga_bus_pkg::DATA_WIDTH-1:0]    wbs_dat_i,
  input  logic [fpga_bus_pkg::DATA_WIDTH-1:0]    device_id_i,
  input  logic [fpga_reg_pkg::MODE_WIDTH-1:0]    mode_sel_i,
  input  logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    pwm_en_i,
  input  logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    idle_pol_i,
  input  logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    gpio_in_i,
  input  logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    gpio_out_i,
  input  logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    gpio_oe_i,
  input  logic [fpga_reg_pkg::NUM_PWM_CH*fpga_reg_pkg::PWM_REG_WIDTH-1:0] duty_i,
  input  logic [fpga_reg_pkg::NUM_PWM_CH*fpga_reg_pkg::PWM_REG_WIDTH-1:0] period_i,
  output logic [fpga_bus_pkg::DATA_WIDTH-1:0]    wbs_dat_o,
  output logic                                   wbs_ack_o,
  output logic                                   id_wr_o,
  output logic                                   mode_wr_o,
  output logic                                   en_pol_wr_o,
  output logic [1:0]                             gpio_out_wr_o,
  output logic [1:0]                             gpio_oe_wr_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    duty_wr_o,
  output logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    period_wr_o,
  output logic [fpga_bus_pkg::BYTE_LANES-1:0]    byte_stb_o,
  output logic [fpga_bus_pkg::DATA_WIDTH-1:0]    wdata_o
);

  logic wr_req;

  // ----------------------------------------------------------------------
  // Acknowledge
  // ----------------------------------------------------------------------
  // A held request sees ack every second cycle
  always_ff @(posedge wbs_clk_i or posedge wbs_rst_i) begin
    if (wbs_rst_i) begin
      wbs_ack_o <= 1'b0;
    end else begin
      wbs_ack_o <= wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
    end
  end

  // ----------------------------------------------------------------------
  // Write decode
  // ----------------------------------------------------------------------
  // Only in the cycle before ack so each access writes once
  assign wr_req = wbs_cyc_i & wbs_stb_i & wbs_we_i & ~wbs_ack_o;

  assign id_wr_o          = wr_req & (wbs_adr_i == fpga_reg_pkg::ADR_DEVICE_ID);
  assign mode_wr_o        = wr_req & (wbs_adr_i == fpga_reg_pkg::ADR_MODE_SEL);
  assign en_pol_wr_o      = wr_req & (wbs_adr_i == fpga_reg_pkg::ADR_PWM_EN_POL);
  assign gpio_out_wr_o[0] = wr_req & (wbs_adr_i == fpga_reg_pkg::ADR_GPIO_OUT_LO);
  assign gpio_out_wr_o[1] = wr_req & (wbs_adr_i == fpga_reg_pkg::ADR_GPIO_OUT_HI);
  assign gpio_oe_wr_o[0]  = wr_req & (wbs_adr_i == fpga_reg_pkg::ADR_GPIO_OE_LO);
  assign gpio_oe_wr_o[1]  = wr_req & (wbs_adr_i == fpga_reg_pkg::ADR_GPIO_OE_HI);

  for (genvar g = 0; g < fpga_reg_pkg::NUM_PWM_CH; g++) begin : g_pwm_dec
    assign duty_wr_o[g]   = wr_req &
                            (int'(wbs_adr_i) == fpga_reg_pkg::ADR_PWM_BASE + 2 * g);
    assign period_wr_o[g] = wr_req &
                            (int'(wbs_adr_i) == fpga_reg_pkg::ADR_PWM_BASE + 2 * g + 1);
  end

  assign byte_stb_o = wbs_byte_stb_i;
  assign wdata_o    = wbs_dat_i;

  // ----------------------------------------------------------------------
  // Read multiplexer
  // ----------------------------------------------------------------------
  always_comb begin
    wbs_dat_o = '0;
    case (wbs_adr_i)
      fpga_reg_pkg::ADR_DEVICE_ID:   wbs_dat_o = device_id_i;
      fpga_reg_pkg::ADR_MODE_SEL:    wbs_dat_o[fpga_reg_pkg::MODE_WIDTH-1:0] = mode_sel_i;
      fpga_reg_pkg::ADR_GPIO_IN_LO:  wbs_dat_o = gpio_in_i[fpga_reg_pkg::GPIO_LO_WIDTH-1:0];
      fpga_reg_pkg::ADR_GPIO_IN_HI:
        wbs_dat_o[fpga_reg_pkg::GPIO_WIDTH-fpga_reg_pkg::GPIO_LO_WIDTH-1:0] =
          gpio_in_i[fpga_reg_pkg::GPIO_WIDTH-1:fpga_reg_pkg::GPIO_LO_WIDTH];
      fpga_reg_pkg::ADR_GPIO_OUT_LO: wbs_dat_o = gpio_out_i[fpga_reg_pkg::GPIO_LO_WIDTH-1:0];
      fpga_reg_pkg::ADR_GPIO_OUT_HI:
        wbs_dat_o[fpga_reg_pkg::GPIO_WIDTH-fpga_reg_pkg::GPIO_LO_WIDTH-1:0] =
          gpio_out_i[fpga_reg_pkg::GPIO_WIDTH-1:fpga_reg_pkg::GPIO_LO_WIDTH];
      fpga_reg_pkg::ADR_GPIO_OE_LO:  wbs_dat_o = gpio_oe_i[fpga_reg_pkg::GPIO_LO_WIDTH-1:0];
      fpga_reg_pkg::ADR_GPIO_OE_HI:
        wbs_dat_o[fpga_reg_pkg::GPIO_WIDTH-fpga_reg_pkg::GPIO_LO_WIDTH-1:0] =
          gpio_oe_i[fpga_reg_pkg::GPIO_WIDTH-1:fpga_reg_pkg::GPIO_LO_WIDTH];
      fpga_reg_pkg::ADR_PWM_EN_POL: begin
        wbs_dat_o[fpga_reg_pkg::NUM_PWM_CH-1:0]  = pwm_en_i;
        wbs_dat_o[8 +: fpga_reg_pkg::NUM_PWM_CH] = idle_pol_i;
      end
      default: begin
        wbs_dat_o = fpga_reg_pkg::DEFAULT_READ_VALUE;
        // PWM channel registers sit above the fixed map
        for (int i = 0; i < fpga_reg_pkg::NUM_PWM_CH; i++) begin
          if (int'(wbs_adr_i) == fpga_reg_pkg::ADR_PWM_BASE + 2 * i) begin
            wbs_dat_o = '0;
            wbs_dat_o[fpga_reg_pkg::PWM_REG_WIDTH-1:0] =
              duty_i[i*fpga_reg_pkg::PWM_REG_WIDTH +: fpga_reg_pkg::PWM_REG_WIDTH];
          end
          if (int'(wbs_adr_i) == fpga_reg_pkg::ADR_PWM_BASE + 2 * i + 1) begin
            wbs_dat_o = '0;
            wbs_dat_o[fpga_reg_pkg::PWM_REG_WIDTH-1:0] =
              period_i[i*fpga_reg_pkg::PWM_REG_WIDTH +: fpga_reg_pkg::PWM_REG_WIDTH];
          end
        end
      end
    endcase
  end

endmodule

/* sim/tb_fpga_reg_top.sv */
// Directed regression of the FPGA register block top level
// Drives the host bus and checks field outputs, readback words
// and the PWM update pulses against a register map model

`timescale 1ns/1ps

module tb_fpga_reg_top;

  logic                                   wbs_clk = 1'b0;
  logic                                   wbs_rst;
  logic [fpga_bus_pkg::ADDR_WIDTH-1:0]    wbs_adr;
  logic                                   wbs_cyc;
  logic                                   wbs_stb;
  logic                                   wbs_we;
  logic [fpga_bus_pkg::BYTE_LANES-1:0]    wbs_byte_stb;
  logic [fpga_bus_pkg::DATA_WIDTH-1:0]    wbs_dat_w;
  logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    gpio_in;
  logic [fpga_bus_pkg::DATA_WIDTH-1:0]    wbs_dat_r;
  logic                                   wbs_ack;
  logic [fpga_bus_pkg::DATA_WIDTH-1:0]    device_id;
  logic [fpga_reg_pkg::MODE_WIDTH-1:0]    mode_sel;
  logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    pwm_en;
  logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    idle_pol;
  logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    gpio_out;
  logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    gpio_oe;
  logic [fpga_reg_pkg::NUM_PWM_CH*fpga_reg_pkg::PWM_REG_WIDTH-1:0] duty;
  logic [fpga_reg_pkg::NUM_PWM_CH*fpga_reg_pkg::PWM_REG_WIDTH-1:0] period;
  logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    duty_upd;
  logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    period_upd;

  // Expected register contents
  logic [fpga_bus_pkg::DATA_WIDTH-1:0]    id_m;
  logic [fpga_reg_pkg::MODE_WIDTH-1:0]    mode_m;
  logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    en_m;
  logic [fpga_reg_pkg::NUM_PWM_CH-1:0]    pol_m;
  logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    out_m;
  logic [fpga_reg_pkg::GPIO_WIDTH-1:0]    oe_m;
  logic [fpga_reg_pkg::NUM_PWM_CH*fpga_reg_pkg::PWM_REG_WIDTH-1:0] duty_m;
  logic [fpga_reg_pkg::NUM_PWM_CH*fpga_reg_pkg::PWM_REG_WIDTH-1:0] period_m;
  int                                     seed = 90;

  fpga_reg_top dut_i (
    .wbs_clk_i (wbs_clk), .wbs_rst_i (wbs_rst), .wbs_adr_i (wbs_adr),
    .wbs_cyc_i (wbs_cyc), .wbs_stb_i (wbs_stb), .wbs_we_i (wbs_we),
    .wbs_byte_stb_i (wbs_byte_stb), .wbs_dat_i (wbs_dat_w), .gpio_in_i (gpio_in),
    .wbs_dat_o (wbs_dat_r), .wbs_ack_o (wbs_ack), .device_id_o (device_id),
    .mode_sel_o (mode_sel), .pwm_en_o (pwm_en), .idle_pol_o (idle_pol),
    .gpio_out_o (gpio_out), .gpio_oe_o (gpio_oe), .duty_o (duty), .period_o (period),
    .duty_upd_o (duty_upd), .period_upd_o (period_upd)
  );

  always #5 wbs_clk = ~wbs_clk;

  // ----------------------------------------------------------------------
  // Reporting and bus access
  // ----------------------------------------------------------------------
  task automatic report_error(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else
      report_error($sformatf("FAILED %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Byte lane merge of a 32-bit register
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [3:0] stb);
    logic [31:0] res;
    res = old;
    for (int l = 0; l < 4; l++) begin
      if (stb[l]) begin
        res[8*l +: 8] = wd[8*l +: 8];
      end
    end
    return res;
  endfunction

  task automatic bus_idle();
    wbs_cyc      = 1'b0;
    wbs_stb      = 1'b0;
    wbs_we       = 1'b0;
    wbs_adr      = '0;
    wbs_byte_stb = '0;
    wbs_dat_w    = '0;
  endtask

  // Returns one ns after the edge where ack rose
  task automatic wait_ack();
    int waited;
    waited = 0;
    do begin
      @(posedge wbs_clk);
      #1;
      waited++;
      if (waited > 8) begin
        report_error("No acknowledge within 8 cycles of a request");
      end
    end while (wbs_ack !== 1'b1);
  endtask

  task automatic wb_write(input logic [fpga_bus_pkg::ADDR_WIDTH-1:0] adr,
                          input logic [3:0] stb, input logic [31:0] data);
    wbs_adr      = adr;
    wbs_cyc      = 1'b1;
    wbs_stb      = 1'b1;
    wbs_we       = 1'b1;
    wbs_byte_stb = stb;
    wbs_dat_w    = data;
    wait_ack();
    bus_idle();
  endtask

  task automatic wb_read(input logic [fpga_bus_pkg::ADDR_WIDTH-1:0] adr,
                         output logic [31:0] data);
    wbs_adr = adr;
    wbs_cyc = 1'b1;
    wbs_stb = 1'b1;
    wait_ack();
    data = wbs_dat_r;
    bus_idle();
  endtask

  task automatic read_check(input logic [fpga_bus_pkg::ADDR_WIDTH-1:0] adr,
                            input logic [31:0] exp);
    logic [31:0] data;
    wb_read(adr, data);
    check_eq($sformatf("wbs_dat_o at address 0x%0h", adr), 64'(data), 64'(exp));
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------
  task automatic test_reset_values();
    check_eq("device_id_o", 64'(device_id), 64'(fpga_reg_pkg::DEVICE_ID_RESET));
    check_eq("wbs_ack_o", 64'(wbs_ack), 64'(0));
    check_eq("duty_upd_o", 64'(duty_upd), 64'(0));
    check_eq("period_upd_o", 64'(period_upd), 64'(0));
    read_check(fpga_reg_pkg::ADR_DEVICE_ID, fpga_reg_pkg::DEVICE_ID_RESET);
    for (int a = 1; a < fpga_reg_pkg::ADR_PWM_BASE + 2 * fpga_reg_pkg::NUM_PWM_CH; a++) begin
      read_check(a[fpga_bus_pkg::ADDR_WIDTH-1:0], '0);
    end
    read_check(7'h20, fpga_reg_pkg::DEFAULT_READ_VALUE);
  endtask

  task automatic test_handshake();
    @(posedge wbs_clk);
    #1;
    check_eq("wbs_ack_o idle", 64'(wbs_ack), 64'(0));
    wbs_adr = fpga_reg_pkg::ADR_DEVICE_ID;
    wbs_cyc = 1'b1;
    wbs_stb = 1'b1;
    // Held request makes ack alternate
    for (int c = 0; c < 4; c++) begin
      @(posedge wbs_clk);
      #1;
      check_eq($sformatf("wbs_ack_o cycle %0d", c), 64'(wbs_ack), 64'(c % 2 == 0));
    end
    bus_idle();
    repeat (2) begin
      @(posedge wbs_clk);
      #1;
      check_eq("wbs_ack_o after release", 64'(wbs_ack), 64'(0));
    end
  endtask

  task automatic test_ctrl_lanes();
    logic [31:0] data;
    logic [3:0]  stb;
    for (int i = 0; i < 16; i++) begin
      stb  = i[3:0];
      data = 32'h8E4D_2B71 ^ {4{i[7:0]}};
      id_m = merge_bytes(id_m, data, stb);
      wb_write(fpga_reg_pkg::ADR_DEVICE_ID, stb, data);
      check_eq("device_id_o", 64'(device_id), 64'(id_m));
      read_check(fpga_reg_pkg::ADR_DEVICE_ID, id_m);
      if (stb[0]) begin
        mode_m = data[fpga_reg_pkg::MODE_WIDTH-1:0];
        en_m   = data[fpga_reg_pkg::NUM_PWM_CH-1:0];
      end
      if (stb[1]) begin
        pol_m = data[8 +: fpga_reg_pkg::NUM_PWM_CH];
      end
      wb_write(fpga_reg_pkg::ADR_MODE_SEL, stb, data);
      check_eq("mode_sel_o", 64'(mode_sel), 64'(mode_m));
      read_check(fpga_reg_pkg::ADR_MODE_SEL, 32'(mode_m));
      wb_write(fpga_reg_pkg::ADR_PWM_EN_POL, stb, data);
      check_eq("pwm_en_o", 64'(pwm_en), 64'(en_m));
      check_eq("idle_pol_o", 64'(idle_pol), 64'(pol_m));
      read_check(fpga_reg_pkg::ADR_PWM_EN_POL, 32'(en_m) | (32'(pol_m) << 8));
    end
  endtask

  task automatic gpio_write_check(input logic is_oe, input logic hi,
                                  input logic [3:0] stb, input logic [31:0] data);
    logic [fpga_reg_pkg::GPIO_WIDTH-1:0] cur;
    logic [fpga_bus_pkg::ADDR_WIDTH-1:0] adr_lo;
    logic [fpga_bus_pkg::ADDR_WIDTH-1:0] adr_hi;
    adr_lo = is_oe ? fpga_reg_pkg::ADR_GPIO_OE_LO : fpga_reg_pkg::ADR_GPIO_OUT_LO;
    adr_hi = is_oe ? fpga_reg_pkg::ADR_GPIO_OE_HI : fpga_reg_pkg::ADR_GPIO_OUT_HI;
    cur = is_oe ? oe_m : out_m;
    if (!hi) begin
      cur[31:0] = merge_bytes(cur[31:0], data, stb);
    end else begin
      // High word holds lane 0 and six bits of lane 1
      if (stb[0]) cur[fpga_reg_pkg::GPIO_LO_WIDTH +: 8] = data[7:0];
      if (stb[1]) cur[fpga_reg_pkg::GPIO_WIDTH-1:fpga_reg_pkg::GPIO_LO_WIDTH+8] = data[13:8];
    end
    if (is_oe) oe_m = cur;
    else out_m = cur;
    wb_write(hi ? adr_hi : adr_lo, stb, data);
    check_eq("gpio_out_o", 64'(gpio_out), 64'(out_m));
    check_eq("gpio_oe_o", 64'(gpio_oe), 64'(oe_m));
    read_check(adr_lo, cur[31:0]);
    read_check(adr_hi, 32'(cur[fpga_reg_pkg::GPIO_WIDTH-1:fpga_reg_pkg::GPIO_LO_WIDTH]));
  endtask

  task automatic test_gpio_out_oe();
    logic [31:0] mask;
    for (int k = 0; k < 2; k++) begin
      mask = (k == 1) ? 32'h0F0F_F0F0 : 32'h0;
      gpio_write_check(k[0], 1'b0, 4'b1111, 32'hDEAD_BEEF ^ mask);
      gpio_write_check(k[0], 1'b1, 4'b1111, 32'hFFFF_FFFF ^ mask);
      gpio_write_check(k[0], 1'b0, 4'b0101, 32'h1234_5678 ^ mask);
      gpio_write_check(k[0], 1'b1, 4'b1100, 32'hA5A5_A5A5 ^ mask);
      gpio_write_check(k[0], 1'b1, 4'b0010, 32'h0000_2A00 ^ mask);
      gpio_write_check(k[0], 1'b1, 4'b0001, 32'h0000_0042 ^ mask);
    end
  endtask

  task automatic test_gpio_in();
    logic [63:0] r;
    for (int n = 0; n < 6; n++) begin
      r = {$random(seed), $random(seed)};
      gpio_in = r[fpga_reg_pkg::GPIO_WIDTH-1:0];
      read_check(fpga_reg_pkg::ADR_GPIO_IN_LO, r[31:0]);
      read_check(fpga_reg_pkg::ADR_GPIO_IN_HI,
                 32'(r[fpga_reg_pkg::GPIO_WIDTH-1:fpga_reg_pkg::GPIO_LO_WIDTH]));
    end
  endtask

  task automatic pwm_write_check(input int ch, input logic is_period,
                                 input logic [3:0] stb, input logic [31:0] data);
    int                                      adr_int;
    logic [fpga_reg_pkg::NUM_PWM_CH-1:0]     onehot;
    logic [fpga_reg_pkg::PWM_REG_WIDTH-1:0]  cur;
    adr_int = fpga_reg_pkg::ADR_PWM_BASE + 2 * ch + int'(is_period);
    onehot = '0;
    onehot[ch] = 1'b1;
    cur = is_period ? period_m[ch*fpga_reg_pkg::PWM_REG_WIDTH +: fpga_reg_pkg::PWM_REG_WIDTH]
                    : duty_m[ch*fpga_reg_pkg::PWM_REG_WIDTH +: fpga_reg_pkg::PWM_REG_WIDTH];
    if (stb[0]) cur[7:0] = data[7:0];
    if (stb[1]) cur[15:8] = data[15:8];
    if (is_period) period_m[ch*fpga_reg_pkg::PWM_REG_WIDTH +: fpga_reg_pkg::PWM_REG_WIDTH] = cur;
    else duty_m[ch*fpga_reg_pkg::PWM_REG_WIDTH +: fpga_reg_pkg::PWM_REG_WIDTH] = cur;
    wb_write(adr_int[fpga_bus_pkg::ADDR_WIDTH-1:0], stb, data);
    check_eq("duty_o", 64'(duty), 64'(duty_m));
    check_eq("period_o", 64'(period), 64'(period_m));
    check_eq("duty_upd_o at ack", 64'(duty_upd), 64'(0));
    check_eq("period_upd_o at ack", 64'(period_upd), 64'(0));
    // Pulse one cycle after ack and low again the cycle after
    @(posedge wbs_clk);
    #1;
    check_eq("duty_upd_o", 64'(duty_upd), is_period ? 64'(0) : 64'(onehot));
    check_eq("period_upd_o", 64'(period_upd), is_period ? 64'(onehot) : 64'(0));
    @(posedge wbs_clk);
    #1;
    check_eq("duty_upd_o after pulse", 64'(duty_upd), 64'(0));
    check_eq("period_upd_o after pulse", 64'(period_upd), 64'(0));
    read_check(adr_int[fpga_bus_pkg::ADDR_WIDTH-1:0], 32'(cur));
  endtask

  task automatic test_pwm_channels();
    for (int ch = 0; ch < fpga_reg_pkg::NUM_PWM_CH; ch++) begin
      pwm_write_check(ch, 1'b0, 4'b0011, {16'hFFFF, ch[7:0], 8'hA5});
      pwm_write_check(ch, 1'b1, 4'b0011, {16'h0000, 8'hC3, ch[7:0]});
      pwm_write_check(ch, 1'b0, 4'b0001, 32'h0000_005A);
      pwm_write_check(ch, 1'b1, 4'b0000, 32'hFFFF_FFFF);
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    wbs_rst  = 1'b1;
    gpio_in  = '0;
    bus_idle();
    id_m     = fpga_reg_pkg::DEVICE_ID_RESET;
    mode_m   = '0;
    en_m     = '0;
    pol_m    = '0;
    out_m    = '0;
    oe_m     = '0;
    duty_m   = '0;
    period_m = '0;
    repeat (10) @(posedge wbs_clk);
    #1;
    wbs_rst = 1'b0;
    test_reset_values();
    test_handshake();
    test_ctrl_lanes();
    test_gpio_out_oe();
    test_gpio_in();
    test_pwm_channels();
    $display("Regression passed");
    $finish;
  end

  // Full run is well under 1000 cycles
  initial begin
    repeat (2000) @(posedge wbs_clk);
    report_error("Watchdog timeout, the regression did not finish in 2000 cycles");
  end

endmodule

/* verilog.f */
rtl/fpga_bus_pkg.sv
rtl/fpga_reg_pkg.sv
rtl/wb_reg_slave.sv
rtl/ctrl_regs.sv
rtl/gpio_regs.sv
rtl/pwm_ch_regs.sv
rtl/fpga_reg_top.sv
sim/tb_fpga_reg_top.sv
